// ==== rvCore.f ====
common/rvCorePkg.sv
source/immGen.sv
decoder/decoder.sv
source/alu.sv
source/regFile.sv
source/rvCore.sv
tests/rvCore_assert.sv
tests/rvCoreTb.sv

// ==== Bender.yml ====
package:
  name: rvCore

sources:
  - common/rvCorePkg.sv
  - source/immGen.sv
  - decoder/decoder.sv
  - source/alu.sv
  - source/regFile.sv
  - source/rvCore.sv
  - target: test
    files:
      - tests/rvCore_assert.sv
      - tests/rvCoreTb.sv

// ==== tests/rvCoreTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module rvCoreTb;

    localparam rvCorePkg::xlenT resetPc    = 64'h0000_0000_8000_0000;
    localparam rvCorePkg::instT ebreakInst = 32'h0010_0073;

    logic               clk;
    logic               rstN;
    rvCorePkg::instT    inst;
    rvCorePkg::xlenT    pc;
    logic               wbEn;
    rvCorePkg::regAddrT wbAddr;
    rvCorePkg::xlenT    wbData;
    logic               halted;

    rvCorePkg::instT imem [0:511];
    // register state the program should leave behind, x0 is never written
    rvCorePkg::xlenT shadow [0:31];
    rvCorePkg::xlenT expPc;
    rvCorePkg::xlenT expData;
    logic            expEn;
    logic            expHalted;
    logic            rstSeen = 1'b0;
    logic [31:0]     lfsr = 32'h1a3b_ab1e;
    int              progLen = 0;
    int              cycles = 0;
    int              cycleLimit = 0;
    int              retired = 0;

    rvCore #(.resetPc(resetPc)) u_rvCore
    (
        .clk    (clk),
        .rstN   (rstN),
        .inst   (inst),
        .pc     (pc),
        .wbEn   (wbEn),
        .wbAddr (wbAddr),
        .wbData (wbData),
        .halted (halted)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic rvCorePkg::instT encR(input rvCorePkg::regAddrT rd, rs1, rs2,
                                             input logic [6:0] f7);
        return {f7, rs2, rs1, 3'b000, rd, rvCorePkg::opRType};
    endfunction

    function automatic rvCorePkg::instT encI(input rvCorePkg::regAddrT rd, rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, rvCorePkg::opIType};
    endfunction

    function automatic rvCorePkg::instT encU(input logic [6:0] op,
                                             input rvCorePkg::regAddrT rd,
                                             input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    task automatic addInst(input rvCorePkg::instT i);
        imem[progLen] = i;
        progLen++;
    endtask

    function automatic rvCorePkg::instT fetch(input rvCorePkg::xlenT addr);
        rvCorePkg::xlenT idx;
        idx = (addr - resetPc) >> 2;
        // past the end of the program the core only sees ebreak
        if ($isunknown(addr) || idx >= progLen)
            return ebreakInst;
        else
            return imem[idx];
    endfunction

    function automatic logic writesRd(input rvCorePkg::instT i);
        return i[6:0] inside {rvCorePkg::opRType, rvCorePkg::opIType,
                              rvCorePkg::opAuipc, rvCorePkg::opLui};
    endfunction

    function automatic logic isEbreak(input rvCorePkg::instT i);
        return i[6:0] == rvCorePkg::opSystem && i[14:12] == 3'b000 && i[31:20] == 12'd1;
    endfunction

    // expected writeback value of one instruction at address p
    function automatic rvCorePkg::xlenT refResult(input rvCorePkg::instT i,
                                                  input rvCorePkg::xlenT p);
        rvCorePkg::xlenT immI;
        rvCorePkg::xlenT immU;
        rvCorePkg::xlenT a;
        rvCorePkg::xlenT b;
        immI = {{52{i[31]}}, i[31:20]};
        immU = {{32{i[31]}}, i[31:12], 12'h000};
        a = shadow[i[19:15]];
        b = shadow[i[24:20]];
        case (i[6:0])
            rvCorePkg::opRType: return (i[14:12] == 3'b000 && i[31:25] == 7'h00) ? a + b : '0;
            rvCorePkg::opIType: return (i[14:12] == 3'b000) ? a + immI : '0;
            rvCorePkg::opAuipc: return p + immU;
            rvCorePkg::opLui:   return immU;
            default:            return '0;
        endcase
    endfunction

    task automatic reportMismatch(input string what, input logic [63:0] got, exp);
        $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        $display("*** TEST FAILED ***");
        $fatal(1, "%s mismatch", what);
    endtask

    task automatic checkWord(input string what, input rvCorePkg::xlenT got, exp);
        if (got !== exp)
            reportMismatch(what, got, exp);
    endtask

    task automatic checkAddr(input string what, input rvCorePkg::regAddrT got, exp);
        if (got !== exp)
            reportMismatch(what, 64'(got), 64'(exp));
    endtask

    task automatic checkBit(input string what, input logic got, exp);
        if (got !== exp)
            reportMismatch(what, 64'(got), 64'(exp));
    endtask

    task automatic checkAssertions();
        if (u_rvCore.u_rvCoreAssert.failCount != 0)
        begin
            $display("a bound assertion on the core failed before %0t ns", $time);
            $display("*** TEST FAILED ***");
            $fatal(1, "assertion failure");
        end
    endtask

    task automatic buildProgram();
        rvCorePkg::regAddrT rd, rs1, rs2;
        logic [1:0]         kind;
        // give every register a known value first
        for (int r = 1; r < 32; r++)
            addInst(encI(rvCorePkg::regAddrT'(r), 5'd0, 12'(randBits(12))));
        addInst(encU(rvCorePkg::opLui, 5'd1, 20'h80000));
        addInst(encI(5'd1, 5'd1, 12'hfff));
        addInst(encU(rvCorePkg::opLui, 5'd2, 20'h12345));
        addInst(encI(5'd2, 5'd2, 12'h678));
        addInst(encI(5'd3, 5'd0, 12'h800));
        addInst(encI(5'd4, 5'd0, 12'h7ff));
        addInst(encU(rvCorePkg::opAuipc, 5'd5, 20'h00001));
        addInst(encI(5'd7, 5'd0, 12'hfff));
        // all ones plus one wraps to zero, doubling wraps through bit 63
        addInst(encI(5'd8, 5'd7, 12'h001));
        addInst(encR(5'd9, 5'd1, 5'd1, 7'h00));
        addInst(encR(5'd0, 5'd1, 5'd2, 7'h00));
        addInst(encR(5'd10, 5'd0, 5'd1, 7'h00));
        addInst(encR(5'd11, 5'd10, 5'd10, 7'h00));
        addInst(encU(rvCorePkg::opAuipc, 5'd12, 20'hfffff));
        addInst(encU(rvCorePkg::opAuipc, 5'd13, 20'h80000));
        for (int n = 0; n < 200; n++)
        begin
            kind = 2'(randBits(2));
            rd   = rvCorePkg::regAddrT'(randBits(5));
            rs1  = rvCorePkg::regAddrT'(randBits(5));
            rs2  = rvCorePkg::regAddrT'(randBits(5));
            case (kind)
                2'd0:    addInst(encR(rd, rs1, rs2, 7'h00));
                2'd1:    addInst(encI(rd, rs1, 12'(randBits(12))));
                2'd2:    addInst(encU(rvCorePkg::opLui, rd, 20'(randBits(20))));
                default: addInst(encU(rvCorePkg::opAuipc, rd, 20'(randBits(20))));
            endcase
        end
        // sub encoding writes zero, a load opcode writes nothing
        addInst(encR(5'd15, 5'd1, 5'd2, 7'h20));
        addInst({12'h004, 5'd2, 3'b011, 5'd16, 7'b0000011});
        addInst(encR(5'd17, 5'd15, 5'd1, 7'h00));
        addInst(ebreakInst);
    endtask

    always @(posedge clk)
    begin
        #2;
        inst = fetch(pc);
    end

    always @(posedge clk)
    begin
        cycles++;
        rstSeen = !rstN;
        if (cycles > cycleLimit)
        begin
            $display("timeout: the program did not finish within %0d cycles", cycleLimit);
            $display("*** TEST FAILED ***");
            $fatal(1, "simulation timed out");
        end
    end

    // outputs are compared mid-cycle, well after inst has settled
    always @(negedge clk)
    begin
        checkAssertions();
        if (!rstN)
        begin
            checkBit("wbEn in reset", wbEn, 1'b0);
            if (rstSeen)
            begin
                checkWord("pc in reset", pc, resetPc);
                checkBit("halted in reset", halted, 1'b0);
            end
            expPc = resetPc;
            expHalted = 1'b0;
        end
        else
        begin
            checkWord("pc", pc, expPc);
            checkBit("halted", halted, expHalted);
            if (expHalted)
                checkBit("wbEn while halted", wbEn, 1'b0);
            else
            begin
                expEn = writesRd(inst);
                checkBit("wbEn", wbEn, expEn);
                if (expEn)
                begin
                    expData = refResult(inst, expPc);
                    checkAddr("wbAddr", wbAddr, inst[11:7]);
                    checkWord("wbData", wbData, expData);
                    if (inst[11:7] != 5'd0)
                        shadow[inst[11:7]] = expData;
                    retired++;
                end
                expPc = expPc + 64'd4;
                if (isEbreak(inst))
                    expHalted = 1'b1;
            end
        end
    end

    initial
    begin
        rstN = 1'b0;
        inst = '0;
        shadow[0] = '0;
        buildProgram();
        cycleLimit = 2 * progLen + 5 + 20;
        repeat (5) @(posedge clk);
        #2;
        rstN = 1'b1;
        while (halted !== 1'b1)
            @(posedge clk);
        repeat (10) @(posedge clk);
        #2;
        rstN = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rstN = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        checkWord("pc after restart", pc, resetPc + 64'd20);
        checkBit("enough instructions retired", retired > 200, 1'b1);
        checkAssertions();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/rvCore_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

// control checks on the core, bound into every rvCore instance
module rvCoreAssert
(
    input logic            clk,
    input logic            rstN,
    input rvCorePkg::xlenT pc,
    input logic            wbEn,
    input logic            halted
);

    int failCount = 0;

    // once halted the core stays halted and retires nothing until reset
    stayHalted: assert property (@(posedge clk)
        (rstN && halted) |=> (!rstN || (halted && !wbEn)))
        else
        begin
            failCount++;
            $error("halted dropped or wbEn rose without a reset");
        end

    holdPcWhenHalted: assert property (@(posedge clk) (rstN && halted) |=> $stable(pc))
        else
        begin
            failCount++;
            $error("pc moved while the core was halted");
        end

    // every enabled cycle moves pc on by one word
    stepPc: assert property (@(posedge clk) (rstN && !halted) |=> pc == $past(pc) + 64'd4)
        else
        begin
            failCount++;
            $error("pc did not advance by 4 after an enabled cycle");
        end

endmodule

bind rvCore rvCoreAssert u_rvCoreAssert
(
    .clk    (clk),
    .rstN   (rstN),
    .pc     (pc),
    .wbEn   (wbEn),
    .halted (halted)
);

`default_nettype wire

// ==== source/rvCore.sv ====
`timescale 1ns/1ns
`default_nettype none

// single-cycle RV64 core for the add/addi/auipc/lui/ebreak subset
module rvCore
#(
    parameter rvCorePkg::xlenT resetPc = 64'h0000_0000_8000_0000
)
(
    input  logic               clk,
    input  logic               rstN,
    input  rvCorePkg::instT    inst,
    output rvCorePkg::xlenT    pc,
    output logic               wbEn,
    output rvCorePkg::regAddrT wbAddr,
    output rvCorePkg::xlenT    wbData,
    output logic               halted
);

    rvCorePkg::xlenT    imm;
    rvCorePkg::aluOpT   aluOp;
    logic               selA;
    logic               selB;
    logic               writeRd;
    logic               isEbreak;
    rvCorePkg::regAddrT rs1Addr;
    rvCorePkg::regAddrT rs2Addr;
    rvCorePkg::xlenT    rs1Data;
    rvCorePkg::xlenT    rs2Data;
    rvCorePkg::xlenT    opA;
    rvCorePkg::xlenT    opB;
    rvCorePkg::xlenT    aluResult;

    assign rs1Addr = inst[19:15];
    assign rs2Addr = inst[24:20];
    assign wbAddr  = inst[11:7];

    // program counter and halt flag
    // the ebreak cycle itself still retires and moves pc on by one word
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            pc     <= resetPc;
            halted <= 1'b0;
        end
        else if (!halted)
        begin
            pc <= pc + rvCorePkg::xlenT'(4);
            if (isEbreak)
            begin
                halted <= 1'b1;
            end
        end
    end

    immGen u_immGen
    (
        .inst (inst),
        .imm  (imm)
    );

    decoder u_decoder
    (
        .inst     (inst),
        .imm      (imm),
        .aluOp    (aluOp),
        .selA     (selA),
        .selB     (selB),
        .writeRd  (writeRd),
        .isEbreak (isEbreak)
    );

    // operand a is rs1 or pc, operand b is rs2 or the immediate
    assign opA = selA ? rs1Data : pc;
    assign opB = selB ? rs2Data : imm;

    alu u_alu
    (
        .op     (aluOp),
        .a      (opA),
        .b      (opB),
        .result (aluResult)
    );

    // no retirement while held in reset or after ebreak
    assign wbEn   = writeRd & ~halted & rstN;
    assign wbData = aluResult;

    regFile u_regFile
    (
        .clk     (clk),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .we      (wbEn),
        .rdAddr  (wbAddr),
        .rdData  (aluResult)
    );

endmodule

`default_nettype wire

// ==== source/regFile.sv ====
`timescale 1ns/1ns
`default_nettype none

// integer register file with x0 hardwired to zero
module regFile
(
    input  logic               clk,
    input  rvCorePkg::regAddrT rs1Addr,
    input  rvCorePkg::regAddrT rs2Addr,
    output rvCorePkg::xlenT    rs1Data,
    output rvCorePkg::xlenT    rs2Data,
    input  logic               we,
    input  rvCorePkg::regAddrT rdAddr,
    input  rvCorePkg::xlenT    rdData
);

    // only x1 to x31 need storage
    rvCorePkg::xlenT regs [1:31];

    always_ff @(posedge clk)
    begin
        if (we && rdAddr != '0)
        begin
            regs[rdAddr] <= rdData;
        end
    end

    // reads see the value before any write on the coming edge
    assign rs1Data = (rs1Addr == '0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == '0) ? '0 : regs[rs2Addr];

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

// two-operand ALU, only add and pass-through of b are needed
module alu
(
    input  rvCorePkg::aluOpT op,
    input  rvCorePkg::xlenT  a,
    input  rvCorePkg::xlenT  b,
    output rvCorePkg::xlenT  result
);

    always_comb
    begin
        case (op)
            rvCorePkg::aluAdd:
            begin
                // carry out of bit 63 is simply dropped
                result = a + b;
            end
            rvCorePkg::aluPassB:
            begin
                result = b;
            end
            default:
            begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== decoder/decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

// control decode for add, addi, auipc, lui and ebreak
module decoder
(
    input  rvCorePkg::instT  inst,
    input  rvCorePkg::xlenT  imm,
    output rvCorePkg::aluOpT aluOp,
    output logic             selA,
    output logic             selB,
    output logic             writeRd,
    output logic             isEbreak
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // ebreak is the system encoding whose 12-bit immediate is one
    assign isEbreak = (opcode == rvCorePkg::opSystem) && (funct3 == 3'b000) &&
                      (imm == rvCorePkg::xlenT'(1));

    always_comb
    begin
        // anything not listed below reads nothing useful and writes nothing
        aluOp   = '0;
        selA    = 1'b0;
        selB    = 1'b0;
        writeRd = 1'b0;

        case (opcode)
            rvCorePkg::opRType:
            begin
                selA    = 1'b1;
                selB    = 1'b1;
                writeRd = 1'b1;
                if (funct3 == 3'b000 && funct7 == 7'b0000000)
                begin
                    aluOp = rvCorePkg::aluAdd;
                end
            end
            rvCorePkg::opIType:
            begin
                selA    = 1'b1;
                selB    = 1'b0;
                writeRd = 1'b1;
                if (funct3 == 3'b000)
                begin
                    aluOp = rvCorePkg::aluAdd;
                end
            end
            rvCorePkg::opAuipc:
            begin
                // pc plus the shifted immediate
                selA    = 1'b0;
                selB    = 1'b0;
                writeRd = 1'b1;
                aluOp   = rvCorePkg::aluAdd;
            end
            rvCorePkg::opLui:
            begin
                selA    = 1'b0;
                selB    = 1'b0;
                writeRd = 1'b1;
                aluOp   = rvCorePkg::aluPassB;
            end
            default:
            begin
                writeRd = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/immGen.sv ====
`timescale 1ns/1ns
`default_nettype none

// builds the 64-bit immediate from the instruction word
module immGen
(
    input  rvCorePkg::instT inst,
    output rvCorePkg::xlenT imm
);

    logic [6:0] opcode;

    assign opcode = inst[6:0];

    always_comb
    begin
        imm = '0;
        case (opcode)
            rvCorePkg::opIType,
            rvCorePkg::opSystem:
            begin
                // 12-bit immediate in the top of the word
                imm = {{52{inst[31]}}, inst[31:20]};
            end
            rvCorePkg::opAuipc,
            rvCorePkg::opLui:
            begin
                // upper 20 bits, low 12 cleared, then extended from bit 31
                imm = {{32{inst[31]}}, inst[31:12], 12'b0};
            end
            default:
            begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== common/rvCorePkg.sv ====
`default_nettype none

// shared types and encodings for the RV64 integer core
package rvCorePkg;

    // one register value, immediate, ALU operand or program counter
    typedef logic [63:0] xlenT;

    // one raw instruction word as fetched
    typedef logic [31:0] instT;

    // index into the 32-entry register file
    typedef logic [4:0] regAddrT;

    // ALU operation code produced by the decoder
    typedef logic [3:0] aluOpT;

    // code zero is left unused on purpose so that an unsupported
    // R-type encoding falls through to a zero result in the ALU
    localparam aluOpT aluAdd   = 4'b0001;
    localparam aluOpT aluPassB = 4'b0010;

    // base opcodes of the supported subset

    // register-register arithmetic
    localparam logic [6:0] opRType  = 7'b0110011;

    // register-immediate arithmetic
    localparam logic [6:0] opIType  = 7'b0010011;

    // add upper immediate to pc
    localparam logic [6:0] opAuipc  = 7'b0010111;

    // load upper immediate
    localparam logic [6:0] opLui    = 7'b0110111;

    // ecall and ebreak live here, only ebreak is recognized
    localparam logic [6:0] opSystem = 7'b1110011;

endpackage

`default_nettype wire
